/* sources.f */
design/fpExecPkg.sv
design/fpIssueRegister.sv
design/fpMiscUnit.sv
design/fpExecLane.sv
design/fpWritebackRegister.sv
design/fpExecStage.sv
test/fpExecStageTb.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= fpExecStageTb
FILELIST ?= sources.f
OBJDIR   ?= obj_dir
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* test/fpExecStageTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP execution stage testbench
// Directed bursts and random traffic checked
// against a cycle model by assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpExecStageTb import fpExecPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int numLanes     = 2;
    localparam int execDepth    = 3;
    localparam int cycleLimit   = 600;
    localparam int randomCycles = 300;

    typedef struct packed {
        logic     valid;
        logic     regValid;
        fpIssueOp op;
        fpData    data;
        fpFlags   flags;
    } modelSlot;

    logic        clk;
    logic        rstN;
    logic        stall;
    logic        clear;
    fpRecovery   recovery;
    fpIssueOp    issue [numLanes];
    fpOperand    bypassData [numLanes][2];
    fpLaneResult result [numLanes];
    fpReplay     replay [numLanes];

    // Slot 0 is the issue register, the last slot feeds writeback
    modelSlot    slots [numLanes][execDepth];
    fpLaneResult expResult [numLanes];
    fpReplay     expReplay [numLanes];

    string  testName;
    integer seed;
    int     cycleCount;
    int     resultsSeen;
    int     replaysSeen;

    fpExecStage #(
        .numLanes (numLanes),
        .execDepth(execDepth)
    ) i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .clear     (clear),
        .recovery  (recovery),
        .issue     (issue),
        .bypassData(bypassData),
        .result    (result),
        .replay    (replay)
    );

    always #4 clk = ~clk;

    // Ring distance from head, so wrapping ranges need no special case
    function automatic logic pointerInRange(input fpRecovery r, input activeListPtr p);
        activeListPtr offset;
        activeListPtr span;
        offset = activeListPtr'(p - r.flushHead);
        span   = activeListPtr'(r.flushTail - r.flushHead);
        return r.toRecovery && (offset <= span);
    endfunction

    // Returns {data, flags}
    function automatic logic [36:0] expectMisc(input fpMiscOp op, input fpData a,
                                               input fpData b);
        logic        aNan;
        logic        bNan;
        logic [31:0] keyA;
        logic [31:0] keyB;
        fpData       d;
        fpFlags      f;
        aNan = (&a[30:23]) && (|a[22:0]);
        bNan = (&b[30:23]) && (|b[22:0]);
        // Map to an unsigned total order, -0 lands just below +0
        keyA = a[31] ? ~a : {1'b1, a[30:0]};
        keyB = b[31] ? ~b : {1'b1, b[30:0]};
        f = '0;
        d = '0;
        case (op)
            opSgnj:  d = {b[31], a[30:0]};
            opSgnjn: d = {!b[31], a[30:0]};
            opSgnjx: d = {a[31] ^ b[31], a[30:0]};
            opMin, opMax: begin
                f[4] = (aNan && !a[22]) || (bNan && !b[22]);
                if (aNan && bNan) begin
                    d = 32'h7fc0_0000;
                end else if (aNan) begin
                    d = b;
                end else if (bNan) begin
                    d = a;
                end else if (op == opMin) begin
                    d = (keyA <= keyB) ? a : b;
                end else begin
                    d = (keyA >= keyB) ? a : b;
                end
            end
            default: d = '0;
        endcase
        return {d, f};
    endfunction

    always @(posedge clk or negedge rstN) begin : model
        modelSlot    s0;
        modelSlot    sLast;
        fpOperand    a;
        fpOperand    b;
        logic [36:0] res;
        if (!rstN) begin
            for (int l = 0; l < numLanes; l++) begin
                expResult[l] <= '0;
                for (int s = 0; s < execDepth; s++) begin
                    slots[l][s] = '0;
                end
            end
        end else begin
            for (int l = 0; l < numLanes; l++) begin
                if (expReplay[l].valid) begin
                    replaysSeen++;
                end
                expResult[l] <= '0;
                if (clear) begin
                    for (int s = 0; s < execDepth; s++) begin
                        slots[l][s].valid = 1'b0;
                    end
                end else if (!stall) begin
                    sLast = slots[l][execDepth-1];
                    if (sLast.valid && sLast.regValid
                        && !pointerInRange(recovery, sLast.op.alPtr)) begin
                        expResult[l] <= '{valid: 1'b1, alPtr: sLast.op.alPtr,
                                          data: sLast.data, flags: sLast.flags};
                        resultsSeen++;
                    end
                    for (int s = execDepth-1; s >= 2; s--) begin
                        slots[l][s] = slots[l][s-1];
                        slots[l][s].valid = slots[l][s-1].valid
                            && !pointerInRange(recovery, slots[l][s-1].op.alPtr);
                    end
                    // Operands are resolved when the op leaves the issue register
                    s0 = slots[l][0];
                    a = s0.op.bypassA ? bypassData[l][0] : s0.op.operandA;
                    b = s0.op.bypassB ? bypassData[l][1] : s0.op.operandB;
                    res = expectMisc(s0.op.op, a.data, b.data);
                    slots[l][1].valid = s0.valid && !pointerInRange(recovery, s0.op.alPtr);
                    slots[l][1].regValid = (!s0.op.useRegA || a.ready)
                        && (!s0.op.useRegB || b.ready);
                    slots[l][1].op    = s0.op;
                    slots[l][1].data  = res[36:5];
                    slots[l][1].flags = res[4:0];
                    slots[l][0] = '0;
                    slots[l][0].valid = issue[l].valid;
                    slots[l][0].op    = issue[l];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < numLanes; l++) begin
            expReplay[l].valid = slots[l][1].valid && !slots[l][1].regValid
                && !stall && !clear && !pointerInRange(recovery, slots[l][1].op.alPtr);
            expReplay[l].op    = slots[l][1].op.op;
            expReplay[l].alPtr = slots[l][1].op.alPtr;
        end
    end

    task automatic reportMismatch(input string what, input int lane,
                                  input logic [63:0] expected, input logic [63:0] actual);
        $display("** Error [%s] lane %0d %s: expected %h, actual %h",
                 testName, lane, what, expected, actual);
        $display("tests failed");
        $fatal(1, "output mismatch");
    endtask

    for (genvar l = 0; l < numLanes; l++) begin : g_check
        assert property (@(posedge clk) disable iff (!rstN)
            result[l].valid == expResult[l].valid)
        else reportMismatch("result valid", l, 64'($sampled(expResult[l].valid)),
                            64'($sampled(result[l].valid)));

        assert property (@(posedge clk) disable iff (!rstN)
            result[l].valid |-> result[l] == expResult[l])
        else reportMismatch("result", l, 64'($sampled(expResult[l])),
                            64'($sampled(result[l])));

        assert property (@(posedge clk) disable iff (!rstN)
            replay[l].valid == expReplay[l].valid)
        else reportMismatch("replay valid", l, 64'($sampled(expReplay[l].valid)),
                            64'($sampled(replay[l].valid)));

        assert property (@(posedge clk) disable iff (!rstN)
            replay[l].valid |-> replay[l] == expReplay[l])
        else reportMismatch("replay", l, 64'($sampled(expReplay[l])),
                            64'($sampled(replay[l])));
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic fpIssueOp makeOp(input fpMiscOp op, input activeListPtr ptr,
                                        input fpData a, input fpData b, input logic useA,
                                        input logic useB, input logic readyA,
                                        input logic readyB);
        fpIssueOp o;
        o          = '0;
        o.valid    = 1'b1;
        o.op       = op;
        o.alPtr    = ptr;
        o.useRegA  = useA;
        o.useRegB  = useB;
        o.operandA = '{data: a, ready: readyA};
        o.operandB = '{data: b, ready: readyB};
        return o;
    endfunction

    // Normals, signed zeros, infinities, quiet and signaling NaNs
    function automatic fpData randomValue();
        logic [31:0] r;
        logic [31:0] m;
        r = $random(seed);
        m = $random(seed);
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return {m[31], 8'(1 + (r[15:8] % 254)), m[22:0]};
            3'd3:    return 32'h0000_0000;
            3'd4:    return 32'h8000_0000;
            3'd5:    return {m[31], 8'hff, 1'b1, m[21:0]};
            3'd6:    return {m[31], 8'hff, 1'b0, m[21:1], 1'b1};
            default: return {m[31], 8'hff, 23'd0};
        endcase
    endfunction

    function automatic fpIssueOp randomOp();
        logic [31:0] r;
        fpIssueOp    o;
        r = $random(seed);
        o = makeOp(fpMiscOp'(3'((r & 32'h7fff_ffff) % 5)), activeListPtr'(r[13:8]),
                   randomValue(), randomValue(), r[16], r[17], r[18] | r[19],
                   r[20] | r[21]);
        o.bypassA = r[22] & r[23];
        o.bypassB = r[24] & r[25];
        return o;
    endfunction

    // Next rising edge with all strobes back to idle
    task automatic stepCycle();
        @(posedge clk);
        for (int l = 0; l < numLanes; l++) begin
            issue[l].valid <= 1'b0;
        end
        stall    <= 1'b0;
        clear    <= 1'b0;
        recovery <= '0;
    endtask

    task automatic settle(input int n);
        repeat (n) stepCycle();
    endtask

    initial begin
        logic [31:0] r;
        seed        = 32'hf36f;
        clk         = 1'b0;
        rstN        = 1'b0;
        stall       = 1'b0;
        clear       = 1'b0;
        recovery    = '0;
        cycleCount  = 0;
        resultsSeen = 0;
        replaysSeen = 0;
        testName    = "reset";
        for (int l = 0; l < numLanes; l++) begin
            issue[l]         = '0;
            bypassData[l][0] = '0;
            bypassData[l][1] = '0;
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        settle(3);

        testName = "sign injection";
        stepCycle();
        issue[0] <= makeOp(opSgnj, 6'd1, 32'h3f80_0000, 32'hc000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opSgnjn, 6'd2, 32'hbf80_0000, 32'h4040_0000, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opSgnjx, 6'd3, 32'hc000_0000, 32'hbf80_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opSgnjn, 6'd4, 32'h7fc0_0001, 32'h8000_0000, 0, 0, 0, 0);
        settle(execDepth + 2);

        testName = "min max";
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd5, 32'h0000_0000, 32'h8000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd6, 32'h8000_0000, 32'h0000_0000, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd7, 32'h7fc0_0001, 32'h3f80_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd8, 32'h4000_0000, 32'h7f80_0005, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd9, 32'h7fc0_0000, 32'hffc0_0001, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd10, 32'h7f80_0005, 32'h7fc0_0000, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd11, 32'hbf80_0000, 32'hc000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd12, 32'h3f80_0000, 32'h4000_0000, 1, 1, 1, 1);
        settle(execDepth + 2);

        testName = "replay";
        stepCycle();
        bypassData[0][1] <= '{data: 32'h4000_0000, ready: 1'b0};
        bypassData[1][0] <= '{data: 32'hc040_0000, ready: 1'b0};
        bypassData[1][1] <= '{data: 32'h3f80_0000, ready: 1'b1};
        issue[0] <= makeOp(opMin, 6'd13, 32'h3f80_0000, 32'h4000_0000, 1, 0, 0, 1);
        issue[1] <= makeOp(opSgnj, 6'd14, 32'h4040_0000, 32'h0, 0, 1, 1, 0);
        issue[1].bypassB <= 1'b1;
        stepCycle();
        issue[0] <= makeOp(opMax, 6'd15, 32'h3f80_0000, 32'h0, 0, 1, 1, 1);
        issue[0].bypassB <= 1'b1;
        issue[1] <= makeOp(opSgnjx, 6'd16, 32'h0, 32'hbf80_0000, 1, 0, 1, 1);
        issue[1].bypassA <= 1'b1;
        settle(execDepth + 2);

        testName = "selective flush";
        stepCycle();
        issue[0] <= makeOp(opSgnj, 6'd61, 32'h3f80_0000, 32'h8000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd20, 32'h3f80_0000, 32'h4000_0000, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd2, 32'h3f80_0000, 32'h4000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opSgnjn, 6'd30, 32'h4040_0000, 32'h0, 1, 1, 1, 1);
        stepCycle();
        issue[0] <= makeOp(opSgnjx, 6'd63, 32'hbf80_0000, 32'hbf80_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMin, 6'd4, 32'h0000_0000, 32'h8000_0000, 1, 1, 1, 1);
        recovery <= '{toRecovery: 1'b1, flushHead: 6'd60, flushTail: 6'd3};
        stepCycle();
        recovery <= '{toRecovery: 1'b1, flushHead: 6'd10, flushTail: 6'd25};
        settle(execDepth + 2);

        testName = "stall";
        stepCycle();
        issue[0] <= makeOp(opSgnjn, 6'd33, 32'h3f80_0000, 32'h3f80_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMin, 6'd34, 32'h7f80_0001, 32'hc000_0000, 1, 1, 0, 1);
        stepCycle();
        issue[0] <= makeOp(opMax, 6'd35, 32'h8000_0000, 32'h0000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opSgnjx, 6'd36, 32'h4000_0000, 32'hc000_0000, 1, 1, 1, 1);
        repeat (4) begin
            stepCycle();
            stall <= 1'b1;
        end
        settle(execDepth + 2);

        testName = "clear";
        stepCycle();
        issue[0] <= makeOp(opSgnj, 6'd40, 32'h4040_0000, 32'h8000_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opMax, 6'd41, 32'h3f80_0000, 32'hbf80_0000, 1, 1, 1, 1);
        stepCycle();
        stepCycle();
        clear <= 1'b1;
        stepCycle();
        issue[0] <= makeOp(opMin, 6'd42, 32'h4000_0000, 32'h3f80_0000, 1, 1, 1, 1);
        issue[1] <= makeOp(opSgnjn, 6'd43, 32'hc040_0000, 32'h8000_0000, 1, 1, 1, 1);
        settle(execDepth + 2);

        testName = "random";
        repeat (randomCycles) begin
            stepCycle();
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                stall <= 1'b1;
            end
            if (r[8:4] == 5'd0) begin
                clear <= 1'b1;
            end
            if (r[11:9] == 3'd0) begin
                recovery <= '{toRecovery: 1'b1, flushHead: r[17:12], flushTail: r[23:18]};
            end
            for (int l = 0; l < numLanes; l++) begin
                if (r[24 + l]) begin
                    issue[l] <= randomOp();
                end
                bypassData[l][0] <= '{data: randomValue(), ready: r[26 + l] | r[28]};
                bypassData[l][1] <= '{data: randomValue(), ready: r[29 + l] | r[31]};
            end
        end
        settle(execDepth + 3);

        if (resultsSeen > 0 && replaysSeen > 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("No result or replay was ever produced");
            $display("tests failed");
            $fatal(1, "no activity");
        end
    end

endmodule

/* design/fpExecStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP execution stage
// Issue register, one lane per issue slot and
// the writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpExecStage import fpExecPkg::*; #(
    parameter int numLanes  = 2,
    parameter int execDepth = 3
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        clear,
    input  fpRecovery   recovery,
    input  fpIssueOp    issue [numLanes],
    input  fpOperand    bypassData [numLanes][2],
    output fpLaneResult result [numLanes],
    output fpReplay     replay [numLanes]
);

    fpIssueOp    laneOp [numLanes];
    fpLaneCtrl   stageCtrl [numLanes];
    fpLaneResult laneResult [numLanes];

    fpIssueRegister #(
        .numLanes(numLanes)
    ) i_issueRegister (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .clear     (clear),
        .recovery  (recovery),
        .issue     (issue),
        .bypassData(bypassData),
        .laneOp    (laneOp),
        .stageCtrl (stageCtrl)
    );

    for (genvar i = 0; i < numLanes; i++) begin : g_lane
        fpExecLane #(
            .execDepth(execDepth)
        ) i_lane (
            .clk       (clk),
            .rstN      (rstN),
            .stall     (stall),
            .clear     (clear),
            .recovery  (recovery),
            .laneOp    (laneOp[i]),
            .stageCtrl (stageCtrl[i]),
            .laneResult(laneResult[i]),
            .replay    (replay[i])
        );
    end

    fpWritebackRegister #(
        .numLanes(numLanes)
    ) i_writebackRegister (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .clear     (clear),
        .laneResult(laneResult),
        .result    (result)
    );

endmodule

/* design/fpWritebackRegister.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP writeback register
// Registers lane results for the writeback port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpWritebackRegister import fpExecPkg::*; #(
    parameter int numLanes = 2
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        clear,
    input  fpLaneResult laneResult [numLanes],
    output fpLaneResult result [numLanes]
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numLanes; i++) begin
                result[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < numLanes; i++) begin
                // Stalled or cleared cycles write a bubble
                result[i].valid <= laneResult[i].valid && !stall && !clear;
                result[i].alPtr <= laneResult[i].alPtr;
                result[i].data  <= laneResult[i].data;
                result[i].flags <= laneResult[i].flags;
            end
        end
    end

    // A clear never lets a result through on the next cycle
    for (genvar i = 0; i < numLanes; i++) begin : g_check
        assert property (@(posedge clk) disable iff (!rstN) clear |=> !result[i].valid)
        else $error("lane %0d wrote a result right after clear", i);
    end

endmodule

/* design/fpExecLane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP execution lane
// Local control pipeline with selective flush,
// replay request and the misc datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpExecLane import fpExecPkg::*; #(
    parameter int execDepth = 3
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        clear,
    input  fpRecovery   recovery,
    input  fpIssueOp    laneOp,
    input  fpLaneCtrl   stageCtrl,
    output fpLaneResult laneResult,
    output fpReplay     replay
);

    localparam int lastStage = execDepth - 2;

    fpLaneCtrl localPipe [execDepth-1];
    fpLaneCtrl nextPipe [execDepth-1];
    logic      stageFlush [execDepth-1];
    fpData     unitData;
    fpFlags    unitFlags;

    always_comb begin
        for (int j = 0; j < execDepth-1; j++) begin
            stageFlush[j] = inFlushRange(recovery, localPipe[j].alPtr);
        end

        // Stage 0 flush is already folded into stageCtrl
        nextPipe[0] = stageCtrl;
        for (int j = 1; j < execDepth-1; j++) begin
            nextPipe[j]       = localPipe[j-1];
            nextPipe[j].valid = localPipe[j-1].valid && !stageFlush[j-1];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int j = 0; j < execDepth-1; j++) begin
                localPipe[j].valid    <= 1'b0;
                localPipe[j].regValid <= 1'b0;
            end
        end else if (clear) begin
            for (int j = 0; j < execDepth-1; j++) begin
                localPipe[j].valid    <= 1'b0;
                localPipe[j].regValid <= 1'b0;
            end
        end else if (!stall) begin
            localPipe <= nextPipe;
        end
    end

    // Replay goes out from the first local stage
    always_comb begin
        replay.valid = localPipe[0].valid && !localPipe[0].regValid
            && !stall && !clear && !stageFlush[0];
        replay.op    = localPipe[0].op;
        replay.alPtr = localPipe[0].alPtr;
    end

    fpMiscUnit #(
        .execDepth(execDepth)
    ) i_miscUnit (
        .clk  (clk),
        .rstN (rstN),
        .stall(stall),
        .op   (laneOp.op),
        .lhs  (laneOp.operandA.data),
        .rhs  (laneOp.operandB.data),
        .data (unitData),
        .flags(unitFlags)
    );

    // Last stage feeds writeback without a register
    always_comb begin
        laneResult.valid = localPipe[lastStage].valid && localPipe[lastStage].regValid
            && !stageFlush[lastStage];
        laneResult.alPtr = localPipe[lastStage].alPtr;
        laneResult.data  = unitData;
        laneResult.flags = unitFlags;
    end

    assert property (@(posedge clk) disable iff (!rstN) stall |-> !replay.valid)
    else $error("replay raised during stall");

endmodule

/* design/fpMiscUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP misc unit
// Sign injection and min/max, pipelined to the
// lane depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpMiscUnit import fpExecPkg::*; #(
    parameter int execDepth = 3
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  fpMiscOp op,
    input  fpData   lhs,
    input  fpData   rhs,
    output fpData   data,
    output fpFlags  flags
);

    fpData  resultNow;
    fpFlags flagsNow;
    logic   lhsNaN;
    logic   rhsNaN;
    logic   lhsSNaN;
    logic   rhsSNaN;
    logic   lhsLess;

    fpData  dataPipe [execDepth-1];
    fpFlags flagsPipe [execDepth-1];

    always_comb begin
        lhsNaN  = (lhs[30:23] == 8'hff) && (lhs[22:0] != '0);
        rhsNaN  = (rhs[30:23] == 8'hff) && (rhs[22:0] != '0);
        lhsSNaN = lhsNaN && !lhs[22];
        rhsSNaN = rhsNaN && !rhs[22];

        // Sign decides first so -0 sorts below +0
        if (lhs[31] != rhs[31]) begin
            lhsLess = lhs[31];
        end else if (!lhs[31]) begin
            lhsLess = lhs[30:0] < rhs[30:0];
        end else begin
            lhsLess = lhs[30:0] > rhs[30:0];
        end

        flagsNow  = '0;
        resultNow = '0;
        unique case (op)
            opSgnj:  resultNow = {rhs[31], lhs[30:0]};
            opSgnjn: resultNow = {~rhs[31], lhs[30:0]};
            opSgnjx: resultNow = {lhs[31] ^ rhs[31], lhs[30:0]};
            opMin, opMax: begin
                flagsNow[flagInvalid] = lhsSNaN || rhsSNaN;
                if (lhsNaN && rhsNaN) begin
                    resultNow = canonicalNaN;
                end else if (lhsNaN) begin
                    resultNow = rhs;
                end else if (rhsNaN) begin
                    resultNow = lhs;
                end else if (op == opMin) begin
                    resultNow = lhsLess ? lhs : rhs;
                end else begin
                    resultNow = lhsLess ? rhs : lhs;
                end
            end
            default: resultNow = '0;
        endcase
    end

    // Computed in stage 0, then one register per local lane stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int j = 0; j < execDepth-1; j++) begin
                dataPipe[j]  <= '0;
                flagsPipe[j] <= '0;
            end
        end else if (!stall) begin
            dataPipe[0]  <= resultNow;
            flagsPipe[0] <= flagsNow;
            for (int j = 1; j < execDepth-1; j++) begin
                dataPipe[j]  <= dataPipe[j-1];
                flagsPipe[j] <= flagsPipe[j-1];
            end
        end
    end

    assign data  = dataPipe[execDepth-2];
    assign flags = flagsPipe[execDepth-2];

endmodule

/* design/fpIssueRegister.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP issue boundary register
// Holds issued ops, picks bypass operands and
// forms stage-0 lane control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fpIssueRegister import fpExecPkg::*; #(
    parameter int numLanes = 2
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      stall,
    input  logic      clear,
    input  fpRecovery recovery,
    input  fpIssueOp  issue [numLanes],
    input  fpOperand  bypassData [numLanes][2],
    output fpIssueOp  laneOp [numLanes],
    output fpLaneCtrl stageCtrl [numLanes]
);

    fpIssueOp issueReg [numLanes];
    fpOperand opA [numLanes];
    fpOperand opB [numLanes];

    // Valid bits drop on reset and on clear
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numLanes; i++) begin
                issueReg[i].valid <= 1'b0;
            end
        end else if (clear) begin
            for (int i = 0; i < numLanes; i++) begin
                issueReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            issueReg <= issue;
        end
    end

    always_comb begin
        for (int i = 0; i < numLanes; i++) begin
            // Bypass value arrives in the cycle the op sits here
            opA[i] = issueReg[i].bypassA ? bypassData[i][0] : issueReg[i].operandA;
            opB[i] = issueReg[i].bypassB ? bypassData[i][1] : issueReg[i].operandB;

            laneOp[i]          = issueReg[i];
            laneOp[i].operandA = opA[i];
            laneOp[i].operandB = opB[i];

            stageCtrl[i].valid = issueReg[i].valid
                && !inFlushRange(recovery, issueReg[i].alPtr);
            // Not ready register source means the op must be replayed
            stageCtrl[i].regValid = (!issueReg[i].useRegA || opA[i].ready)
                && (!issueReg[i].useRegB || opB[i].ready);
            stageCtrl[i].op    = issueReg[i].op;
            stageCtrl[i].alPtr = issueReg[i].alPtr;
        end
    end

    // A valid op in the register always carries a legal op code
    for (genvar i = 0; i < numLanes; i++) begin : g_check
        assert property (@(posedge clk) disable iff (!rstN)
            issueReg[i].valid
            |-> issueReg[i].op inside {opSgnj, opSgnjn, opSgnjx, opMin, opMax})
        else $error("lane %0d holds a valid op with an illegal misc op code", i);
    end

endmodule

/* design/fpExecPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP execution stage package
// Widths, op codes, pipeline structs and the
// selective flush range check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fpExecPkg;

    localparam int activeListPtrWidth = 6;

    typedef logic [31:0] fpData;
    typedef logic [4:0] fpFlags;
    typedef logic [activeListPtrWidth-1:0] activeListPtr;

    // Invalid operation is bit 4 of the RISC-V fflags
    localparam int flagInvalid = 4;
    localparam fpData canonicalNaN = 32'h7fc0_0000;

    typedef enum logic [2:0] {
        opSgnj  = 3'd0,
        opSgnjn = 3'd1,
        opSgnjx = 3'd2,
        opMin   = 3'd3,
        opMax   = 3'd4
    } fpMiscOp;

    typedef struct packed {
        fpData data;
        logic  ready;
    } fpOperand;

    // One op as delivered by register read
    typedef struct packed {
        logic         valid;
        fpMiscOp      op;
        activeListPtr alPtr;
        logic         useRegA;
        logic         useRegB;
        logic         bypassA;
        logic         bypassB;
        fpOperand     operandA;
        fpOperand     operandB;
    } fpIssueOp;

    // Control carried down a lane's local pipeline
    typedef struct packed {
        logic         valid;
        logic         regValid;
        fpMiscOp      op;
        activeListPtr alPtr;
    } fpLaneCtrl;

    typedef struct packed {
        logic         toRecovery;
        activeListPtr flushHead;
        activeListPtr flushTail;
    } fpRecovery;

    typedef struct packed {
        logic         valid;
        activeListPtr alPtr;
        fpData        data;
        fpFlags       flags;
    } fpLaneResult;

    typedef struct packed {
        logic         valid;
        fpMiscOp      op;
        activeListPtr alPtr;
    } fpReplay;

    // Head and tail both inclusive, range may wrap around the ring
    function automatic logic inFlushRange(input fpRecovery rec, input activeListPtr ptr);
        logic inRange;
        if (rec.flushHead <= rec.flushTail) begin
            inRange = (ptr >= rec.flushHead) && (ptr <= rec.flushTail);
        end else begin
            inRange = (ptr >= rec.flushHead) || (ptr <= rec.flushTail);
        end
        return rec.toRecovery && inRange;
    endfunction

endpackage
